// File: hdl/eeprom_pkg.sv
package eeprom_pkg;

    localparam int ADDR_W = 11;   // 2 KB, upper 3 bits go in the control byte
    localparam int DATA_W = 8;

    // fixed device type of a 24Cxx part
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // bit level commands from the sequencer to the bit engine
    typedef enum logic [1:0]
    {
        CMD_START = 2'd0,
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,
        CMD_READ  = 2'd3
    } i2c_cmd_t;

    // one-hot byte sequencer states
    typedef enum logic [10:0]
    {
        S_IDLE   = 11'b000_0000_0001,
        S_START  = 11'b000_0000_0010,
        S_CTRL_W = 11'b000_0000_0100,
        S_ADDR   = 11'b000_0000_1000,
        S_DATA_W = 11'b000_0001_0000,
        S_RSTART = 11'b000_0010_0000,
        S_CTRL_R = 11'b000_0100_0000,
        S_DATA_R = 11'b000_1000_0000,
        S_MNACK  = 11'b001_0000_0000,
        S_STOP   = 11'b010_0000_0000,
        S_FINISH = 11'b100_0000_0000
    } seq_state_t;

endpackage

// File: hdl/i2c_bit_if.sv
`timescale 1ns/1ps

interface i2c_bit_if
    import eeprom_pkg::*;
(
    input logic CLK
);

    i2c_cmd_t cmd;
    logic     cmd_valid;   // held with cmd and tx_bit until done
    logic     tx_bit;
    logic     rx_bit;      // valid while done is high
    logic     done;        // single cycle, end of the bit

    modport seq
    (
        input  CLK,
        output cmd,
        output cmd_valid,
        output tx_bit,
        input  rx_bit,
        input  done
    );

    modport engine
    (
        input  CLK,
        input  cmd,
        input  cmd_valid,
        input  tx_bit,
        output rx_bit,
        output done
    );

endinterface

// File: hdl/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine
    import eeprom_pkg::*;
#(
    parameter int CLK_DIV = 4
)
(
    input  logic      CLK,
    input  logic      RESET,
    i2c_bit_if.engine bit_bus,
    output logic      scl,
    output logic      sda_oe,
    input  logic      sda_in
);

    localparam int QW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [QW-1:0] Q_LAST = QW'(CLK_DIV - 1);

    logic          busy;
    logic [QW-1:0] qcnt;      // cycles within a quarter
    logic [1:0]    phase;     // quarter of the SCL period
    i2c_cmd_t      cmd_q;
    logic          tx_q;
    logic          rx_q;
    logic          accept;
    logic          q_end;
    logic          sample;

    // line levels {scl, sda_oe} for one quarter of a command
    function automatic logic [1:0] line_state(input i2c_cmd_t cmd, input logic [1:0] ph,
                                              input logic tx, input logic scl_now);
        logic [1:0] res;
        res = {scl_now, 1'b0};
        case (cmd)
            CMD_START:
            begin
                case (ph)
                    2'd0:    res = {scl_now, 1'b0};   // release sda first
                    2'd1:    res = 2'b10;
                    2'd2:    res = 2'b11;             // sda falls, scl high
                    default: res = 2'b01;
                endcase
            end
            CMD_STOP:
            begin
                case (ph)
                    2'd0:       res = 2'b01;
                    2'd1, 2'd2: res = 2'b11;
                    default:    res = 2'b10;          // sda rises, scl high
                endcase
            end
            CMD_WRITE:
                res = {(ph == 2'd1) || (ph == 2'd2), ~tx};
            default:
                res = {(ph == 2'd1) || (ph == 2'd2), 1'b0};
        endcase
        return res;
    endfunction

    assign accept = !busy && bit_bus.cmd_valid;
    assign q_end  = busy && (qcnt == Q_LAST);
    assign sample = busy && (cmd_q == CMD_READ) && (phase == 2'd2) && (qcnt == '0);

    assign bit_bus.done   = q_end && (phase == 2'd3);
    assign bit_bus.rx_bit = rx_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy   <= 1'b0;
            qcnt   <= '0;
            phase  <= 2'd0;
            scl    <= 1'b1;
            sda_oe <= 1'b0;
        end
        else if (accept)
        begin
            busy  <= 1'b1;
            qcnt  <= '0;
            phase <= 2'd0;
            {scl, sda_oe} <= line_state(bit_bus.cmd, 2'd0, bit_bus.tx_bit, scl);
        end
        else if (q_end)
        begin
            qcnt  <= '0;
            phase <= phase + 2'd1;
            if (phase == 2'd3)
                busy <= 1'b0;   // lines hold their last quarter
            else
                {scl, sda_oe} <= line_state(cmd_q, phase + 2'd1, tx_q, scl);
        end
        else if (busy)
        begin
            qcnt <= qcnt + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cmd_q <= bit_bus.cmd;
            tx_q  <= bit_bus.tx_bit;
        end
        if (sample)
            rx_q <= sda_in;   // midpoint of scl high
    end

endmodule

// File: hdl/eeprom_sequencer.sv
`timescale 1ns/1ps

module eeprom_sequencer
    import eeprom_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [ADDR_W-1:0] wb_adr,
    input  logic [DATA_W-1:0] wb_dat_w,
    output logic [DATA_W-1:0] wb_dat_r,
    output logic              wb_ack,
    output logic              wb_err,
    i2c_bit_if.seq            bit_bus
);

    seq_state_t        state;
    logic [3:0]        bit_cnt;   // 0..7 data, 8 is the slave ack
    logic              nack_q;
    logic              we_q;
    logic [ADDR_W-1:0] adr_q;
    logic [DATA_W-1:0] dat_q;
    logic [DATA_W-1:0] shreg;
    logic [DATA_W-1:0] rd_q;
    logic              ack_bit;
    logic              step;
    logic [DATA_W-1:0] ctrl_wr;
    logic [DATA_W-1:0] ctrl_rd;

    assign ack_bit = (bit_cnt == 4'd8);
    assign step    = bit_bus.cmd_valid && bit_bus.done;

    // device code, block bits, r/w
    assign ctrl_wr = {DEV_CODE, adr_q[ADDR_W-1 -: 3], 1'b0};
    assign ctrl_rd = {DEV_CODE, adr_q[ADDR_W-1 -: 3], 1'b1};

    assign wb_ack   = (state == S_FINISH) && !nack_q;
    assign wb_err   = (state == S_FINISH) && nack_q;
    assign wb_dat_r = rd_q;

    // command for the current state, msb first
    always_comb
    begin
        bit_bus.cmd_valid = 1'b1;
        bit_bus.tx_bit    = shreg[DATA_W-1];
        bit_bus.cmd       = CMD_STOP;
        case (state)
            S_START, S_RSTART:
                bit_bus.cmd = CMD_START;
            S_CTRL_W, S_ADDR, S_DATA_W, S_CTRL_R:
                bit_bus.cmd = ack_bit ? CMD_READ : CMD_WRITE;
            S_DATA_R:
                bit_bus.cmd = CMD_READ;
            S_MNACK:
            begin
                bit_bus.cmd    = CMD_WRITE;
                bit_bus.tx_bit = 1'b1;   // no ack ends the read
            end
            S_STOP:
                bit_bus.cmd = CMD_STOP;
            default:
                bit_bus.cmd_valid = 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= S_IDLE;
            bit_cnt <= 4'd0;
            nack_q  <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    bit_cnt <= 4'd0;
                    if (wb_cyc && wb_stb)
                    begin
                        nack_q <= 1'b0;
                        state  <= S_START;
                    end
                end
                S_START:
                    if (step)
                        state <= S_CTRL_W;
                S_RSTART:
                    if (step)
                        state <= S_CTRL_R;
                S_CTRL_W, S_ADDR, S_DATA_W, S_CTRL_R:
                begin
                    if (step && ack_bit)
                    begin
                        bit_cnt <= 4'd0;
                        if (bit_bus.rx_bit)
                        begin
                            nack_q <= 1'b1;   // memory did not answer
                            state  <= S_STOP;
                        end
                        else if (state == S_CTRL_W)
                            state <= S_ADDR;
                        else if (state == S_ADDR)
                            state <= we_q ? S_DATA_W : S_RSTART;
                        else if (state == S_DATA_W)
                            state <= S_STOP;
                        else
                            state <= S_DATA_R;
                    end
                    else if (step)
                        bit_cnt <= bit_cnt + 4'd1;
                end
                S_DATA_R:
                begin
                    if (step && (bit_cnt == 4'd7))
                    begin
                        bit_cnt <= 4'd0;
                        state   <= S_MNACK;
                    end
                    else if (step)
                        bit_cnt <= bit_cnt + 4'd1;
                end
                S_MNACK:
                    if (step)
                        state <= S_STOP;
                S_STOP:
                    if (step)
                        state <= S_FINISH;
                S_FINISH:
                    state <= S_IDLE;   // ack or err is out this cycle
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // request latch and shift register
    always_ff @(posedge CLK)
    begin
        if ((state == S_IDLE) && wb_cyc && wb_stb)
        begin
            we_q  <= wb_we;
            adr_q <= wb_adr;
            dat_q <= wb_dat_w;
        end

        if (step)
        begin
            case (state)
                S_START:
                    shreg <= ctrl_wr;
                S_RSTART:
                    shreg <= ctrl_rd;
                S_CTRL_W:
                    shreg <= ack_bit ? adr_q[DATA_W-1:0] : {shreg[DATA_W-2:0], 1'b0};
                S_ADDR:
                    shreg <= ack_bit ? dat_q : {shreg[DATA_W-2:0], 1'b0};
                S_DATA_W, S_CTRL_R:
                    shreg <= {shreg[DATA_W-2:0], 1'b0};
                S_DATA_R:
                begin
                    shreg <= {shreg[DATA_W-2:0], bit_bus.rx_bit};
                    if (bit_cnt == 4'd7)
                        rd_q <= {shreg[DATA_W-2:0], bit_bus.rx_bit};
                end
                default:
                    shreg <= shreg;
            endcase
        end
    end

endmodule

// File: hdl/eeprom_master_top.sv
`timescale 1ns/1ps

module eeprom_master_top
    import eeprom_pkg::*;
#(
    parameter int CLK_DIV = 4   // CLK cycles per scl quarter
)
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [ADDR_W-1:0] wb_adr,
    input  logic [DATA_W-1:0] wb_dat_w,
    output logic [DATA_W-1:0] wb_dat_r,
    output logic              wb_ack,
    output logic              wb_err,
    output logic              scl,
    output logic              sda_oe,
    input  logic              sda_in
);

    i2c_bit_if bit_bus (.CLK(CLK));

    eeprom_sequencer i_eeprom_sequencer
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err),
        .bit_bus  (bit_bus.seq)
    );

    i2c_bit_engine #(.CLK_DIV(CLK_DIV)) i_i2c_bit_engine
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .bit_bus (bit_bus.engine),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .sda_in  (sda_in)
    );

endmodule

// File: tb/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model
    import eeprom_pkg::*;
(
    input  logic scl,
    input  logic sda,        // wired line as seen on the bus
    input  logic nack_en,
    output logic sda_oe      // pull sda low
);

    logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];
    logic [DATA_W-1:0] shreg;
    logic [DATA_W-1:0] txd;
    logic [3:0]        cnt;        // 8 = byte in, 9 = ack slot
    logic [1:0]        byte_idx;   // 0 control, 1 word address, 2 data
    logic              active;
    logic              rd_mode;
    logic              rd_next;
    logic              acked;
    logic [2:0]        blk;
    logic [ADDR_W-1:0] ptr;
    logic              scl_d;
    logic              sda_d;

    initial
    begin
        for (int i = 0; i < (1 << ADDR_W); i++)
            mem[i] = 8'hFF;
        sda_oe   = 1'b0;
        active   = 1'b0;
        rd_mode  = 1'b0;
        rd_next  = 1'b0;
        acked    = 1'b0;
        cnt      = 4'd0;
        byte_idx = 2'd0;
        blk      = 3'd0;
        ptr      = '0;
        shreg    = '0;
        txd      = '0;
        scl_d    = 1'b1;
        sda_d    = 1'b1;
        forever
        begin
            @(scl or sda);
            if (scl && scl_d && sda_d && !sda)
            begin
                // start or repeated start
                active   = 1'b1;
                cnt      = 4'd0;
                byte_idx = 2'd0;
                rd_mode  = 1'b0;
                rd_next  = 1'b0;
                sda_oe   = 1'b0;
            end
            else if (scl && scl_d && !sda_d && sda)
            begin
                active  = 1'b0;   // stop
                rd_mode = 1'b0;
                sda_oe  = 1'b0;
            end
            else if (scl && !scl_d)
            begin
                if (active && (cnt < 4'd8))
                begin
                    shreg = {shreg[DATA_W-2:0], sda};
                    cnt   = cnt + 4'd1;
                end
            end
            else if (!scl && scl_d && active)
            begin
                if (rd_mode)
                begin
                    if (cnt < 4'd8)
                        sda_oe = ~txd[3'd7 - cnt[2:0]];
                    else
                        sda_oe = 1'b0;   // master acks or nacks here
                end
                else if (cnt == 4'd8)
                begin
                    acked = !nack_en;
                    case (byte_idx)
                        2'd0:
                        begin
                            if (shreg[7:4] != DEV_CODE)
                                acked = 1'b0;
                            blk     = shreg[3:1];
                            rd_next = shreg[0];
                        end
                        2'd1:
                            ptr = {blk, shreg};
                        default:
                            if (acked)
                                mem[ptr] = shreg;
                    endcase
                    sda_oe = acked;
                    cnt    = 4'd9;
                end
                else if (cnt == 4'd9)
                begin
                    sda_oe   = 1'b0;
                    cnt      = 4'd0;
                    byte_idx = byte_idx + 2'd1;
                    if (!acked)
                        active = 1'b0;
                    else if (rd_next)
                    begin
                        rd_mode = 1'b1;
                        txd     = mem[ptr];
                        sda_oe  = ~txd[7];   // first data bit right after ack
                    end
                end
            end
            scl_d = scl;
            sda_d = sda;
        end
    end

endmodule

// File: tb/eeprom_asserts.sv
`timescale 1ns/1ps

module eeprom_asserts
    import eeprom_pkg::*;
(
    input logic       CLK,
    input logic       RESET,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic       wb_err,
    input logic       scl,
    input logic       sda_oe,
    input seq_state_t state
);

    a_ack_err_excl: assert property (@(posedge CLK) disable iff (RESET) !(wb_ack && wb_err))
        else $error("wb_ack and wb_err high together");

    a_ack_pulse: assert property (@(posedge CLK) disable iff (RESET) wb_ack |=> !wb_ack)
        else $error("wb_ack longer than one cycle");

    a_err_pulse: assert property (@(posedge CLK) disable iff (RESET) wb_err |=> !wb_err)
        else $error("wb_err longer than one cycle");

    a_resp_in_cycle: assert property (@(posedge CLK) disable iff (RESET)
        (wb_ack || wb_err) |-> (wb_cyc && wb_stb))
        else $error("response outside a bus cycle");

    a_reset_sda: assert property (@(posedge CLK) RESET |=> !sda_oe)
        else $error("sda pulled low during reset");

    // bus free between transactions
    a_idle_bus_free: assert property (@(posedge CLK) disable iff (RESET)
        (state == S_IDLE) |-> (scl && !sda_oe))
        else $error("serial bus not released while the sequencer is idle");

endmodule

bind eeprom_master_top eeprom_asserts i_eeprom_asserts
(
    .CLK    (CLK),
    .RESET  (RESET),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .wb_err (wb_err),
    .scl    (scl),
    .sda_oe (sda_oe),
    .state  (i_eeprom_sequencer.state)
);

// File: tb/tb_eeprom.sv
`timescale 1ns/1ps

module tb_eeprom
    import eeprom_pkg::*;
;

    localparam int CLK_DIV   = 4;
    localparam int N_ROWS    = 29;                   // 9 fixed, 20 random
    localparam int TXN_LIMIT = 45 * 4 * CLK_DIV + 8; // cycles per transaction

    logic              CLK;
    logic              RESET;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat_w;
    logic [DATA_W-1:0] wb_dat_r;
    logic              wb_ack;
    logic              wb_err;
    logic              scl;
    logic              sda_oe;
    logic              model_oe;
    logic              nack_en;
    wire               sda_line;

    string             row_name [N_ROWS];
    logic              row_we   [N_ROWS];
    logic [ADDR_W-1:0] row_adr  [N_ROWS];
    logic [DATA_W-1:0] row_dat  [N_ROWS];   // write data or expected read data
    logic              row_nack [N_ROWS];
    logic              row_err  [N_ROWS];
    logic [DATA_W-1:0] shadow   [0:(1 << ADDR_W)-1];
    int                n_rows;
    int                errors;

    assign sda_line = !(sda_oe || model_oe);   // open drain with pull-up

    eeprom_master_top #(.CLK_DIV(CLK_DIV)) i_eeprom_master_top
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda_line)
    );

    eeprom_model i_eeprom_model
    (
        .scl     (scl),
        .sda     (sda_line),
        .nack_en (nack_en),
        .sda_oe  (model_oe)
    );

    always #2 CLK = ~CLK;

    task automatic add_row(input string name, input logic we, input logic [ADDR_W-1:0] adr,
                           input logic [DATA_W-1:0] dat, input logic nack, input logic err);
        row_name[n_rows] = name;
        row_we[n_rows]   = we;
        row_adr[n_rows]  = adr;
        row_dat[n_rows]  = dat;
        row_nack[n_rows] = nack;
        row_err[n_rows]  = err;
        if (we && !nack)
            shadow[adr] = dat;
        n_rows++;
    endtask

    task automatic run_row(input int i);
        int                waited;
        logic              got_ack;
        logic              got_err;
        logic [DATA_W-1:0] got_dat;
        @(posedge CLK);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= row_we[i];
        wb_adr   <= row_adr[i];
        wb_dat_w <= row_we[i] ? row_dat[i] : 8'h00;
        nack_en  <= row_nack[i];
        waited = 0;
        @(negedge CLK);
        while (!(wb_ack || wb_err) && (waited < TXN_LIMIT))
        begin
            @(negedge CLK);
            waited++;
        end
        got_ack = wb_ack;
        got_err = wb_err;
        got_dat = wb_dat_r;
        @(posedge CLK);
        wb_cyc  <= 1'b0;
        wb_stb  <= 1'b0;
        nack_en <= 1'b0;
        assert (waited < TXN_LIMIT)
        else
        begin
            $display("timeout: row %s got neither ack nor err within %0d cycles",
                     row_name[i], TXN_LIMIT);
            errors++;
        end
        if (waited < TXN_LIMIT)
        begin
            assert (got_err == row_err[i] && got_ack == !row_err[i])
            else
            begin
                $display("mismatch %s: expected ack/err %0b%0b, actual %0b%0b", row_name[i],
                         !row_err[i], row_err[i], got_ack, got_err);
                errors++;
            end
            if (!row_we[i] && !row_err[i])
            begin
                assert (got_dat == row_dat[i])
                else
                begin
                    $display("mismatch %s: expected %02h, actual %02h", row_name[i],
                             row_dat[i], got_dat);
                    errors++;
                end
            end
        end
    endtask

    // watchdog
    initial
    begin
        #(N_ROWS * (45 * 16 + 8) * 4 + 10 * 4);
        $display("timeout: run exceeded its time budget");
        $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        logic [31:0]       rnd;
        logic [ADDR_W-1:0] r_adr;
        logic [DATA_W-1:0] r_dat;
        void'($urandom(32'he94c4b79));
        CLK      = 1'b0;
        RESET    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        nack_en  = 1'b0;
        errors   = 0;
        n_rows   = 0;
        for (int a = 0; a < (1 << ADDR_W); a++)
            shadow[a] = 8'hFF;

        add_row("w_basic", 1'b1, 11'h123, 8'h5A, 1'b0, 1'b0);
        add_row("r_basic", 1'b0, 11'h123, 8'h5A, 1'b0, 1'b0);
        add_row("w_blk0", 1'b1, 11'h045, 8'h11, 1'b0, 1'b0);
        add_row("w_blk5", 1'b1, 11'h545, 8'h22, 1'b0, 1'b0);
        add_row("r_blk0", 1'b0, 11'h045, 8'h11, 1'b0, 1'b0);
        add_row("r_blk5", 1'b0, 11'h545, 8'h22, 1'b0, 1'b0);
        add_row("r_blank", 1'b0, 11'h7FE, 8'hFF, 1'b0, 1'b0);
        add_row("w_nack", 1'b1, 11'h123, 8'hC3, 1'b1, 1'b1);
        add_row("r_after_nack", 1'b0, 11'h123, 8'h5A, 1'b0, 1'b0);
        for (int k = 0; k < 10; k++)
        begin
            rnd   = $urandom();
            r_adr = rnd[ADDR_W-1:0];
            r_dat = rnd[23:16];
            add_row($sformatf("w_rand%0d", k), 1'b1, r_adr, r_dat, 1'b0, 1'b0);
            add_row($sformatf("r_rand%0d", k), 1'b0, r_adr, shadow[r_adr], 1'b0, 1'b0);
        end

        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        assert (scl === 1'b1 && sda_oe === 1'b0 && wb_ack === 1'b0 && wb_err === 1'b0)
        else
        begin
            $display("bus lines not idle after reset: scl %b sda_oe %b ack %b err %b",
                     scl, sda_oe, wb_ack, wb_err);
            errors++;
        end

        for (int i = 0; i < n_rows; i++)
            run_row(i);

        $display("rows run: %0d, errors: %0d", n_rows, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: compile.f
hdl/eeprom_pkg.sv
hdl/i2c_bit_if.sv
hdl/i2c_bit_engine.sv
hdl/eeprom_sequencer.sv
hdl/eeprom_master_top.sv
tb/eeprom_model.sv
tb/eeprom_asserts.sv
tb/tb_eeprom.sv

// File: run.sh
#!/bin/sh
# build and run the EEPROM master testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_eeprom -f compile.f \
    -o Vtb_eeprom > sim.log 2>&1 \
    && ./obj_dir/Vtb_eeprom >> sim.log 2>&1 \
    || { cat sim.log; echo "build or simulation aborted"; exit 1; }

cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
